//--- source/soc_pkg.sv
`default_nettype none

package soc_pkg;

    typedef logic [31:0] addr_t;                    // bus byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  sel_t;                     // one lane per data byte
    typedef logic [3:0]  region_t;                  // address bits 31:28

    localparam region_t REGION_TCM     = 4'd0;
    localparam region_t REGION_UART    = 4'd1;
    localparam region_t REGION_COUNTER = 4'd2;

    localparam int TCM_ADDR_WIDTH = 10;
    localparam int TCM_WORDS      = 2 ** TCM_ADDR_WIDTH;

    typedef logic [TCM_ADDR_WIDTH-1:0] tcm_addr_t;  // byte address bits 11:2

    localparam logic [1:0] UART_REG_DATA   = 2'd0;
    localparam logic [1:0] UART_REG_STATUS = 2'd1;
    localparam logic [1:0] UART_REG_BAUD   = 2'd2;

    typedef logic [15:0] baud_t;                    // clocks per serial bit

    localparam baud_t UART_BAUD_RESET = 16'd16;
    localparam int    UART_DATA_BITS  = 8;

    localparam int RST_HOLD_CYCLES = 4;
    localparam int RST_CNT_WIDTH   = $clog2(RST_HOLD_CYCLES + 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_e;

endpackage

`default_nettype wire

//--- source/wb_slave_if.sv
`timescale 1ns/1ns
`default_nettype none

interface wb_slave_if;

    soc_pkg::addr_t adr;
    soc_pkg::data_t wdat;
    soc_pkg::sel_t  sel;
    bit             we;
    bit             dev_sel;        // cyc & stb & region hit
    soc_pkg::data_t rdat;
    bit             ack;

    modport fabric
    (
        output adr,
        output wdat,
        output sel,
        output we,
        output dev_sel,
        input  rdat,
        input  ack
    );

    modport peripheral
    (
        input  adr,
        input  wdat,
        input  sel,
        input  we,
        input  dev_sel,
        output rdat,
        output ack
    );

endinterface

`default_nettype wire

//--- source/reset_filter.sv
`timescale 1ns/1ns
`default_nettype none

module reset_filter
(
    input  logic w_clk,
    input  logic i_rst,
    output logic o_rst
);

    logic [soc_pkg::RST_CNT_WIDTH-1:0] r_cnt;   // clean low samples seen so far

    always_ff @(posedge w_clk)
    begin
        if (i_rst)
        begin
            r_cnt <= '0;
            o_rst <= 1'b1;
        end
        else if (r_cnt != soc_pkg::RST_HOLD_CYCLES)
        begin
            r_cnt <= r_cnt + 1'b1;
            o_rst <= (r_cnt != soc_pkg::RST_HOLD_CYCLES - 1);   // last low sample releases
        end
    end

endmodule

`default_nettype wire

//--- source/bus_fabric.sv
`timescale 1ns/1ns
`default_nettype none

module bus_fabric
(
    input  logic           w_clk,
    input  logic           i_rst,
    input  logic           i_wb_cyc,
    input  logic           i_wb_stb,
    input  logic           i_wb_we,
    input  soc_pkg::addr_t i_wb_adr,
    input  soc_pkg::sel_t  i_wb_sel,
    input  soc_pkg::data_t i_wb_dat,
    output soc_pkg::data_t o_wb_dat,
    output logic           o_wb_ack,
    wb_slave_if.fabric     tcm_bus,
    wb_slave_if.fabric     uart_bus
);

    soc_pkg::region_t w_region;
    logic             w_req;
    logic             w_local;      // counter or unmapped region answered here
    logic             r_ack;
    soc_pkg::data_t   r_cnt;

    assign w_region = i_wb_adr[31:28];
    assign w_req    = i_wb_cyc & i_wb_stb;
    assign w_local  = (w_region != soc_pkg::REGION_TCM) && (w_region != soc_pkg::REGION_UART);

    assign tcm_bus.adr      = i_wb_adr;
    assign tcm_bus.wdat     = i_wb_dat;
    assign tcm_bus.sel      = i_wb_sel;
    assign tcm_bus.we       = i_wb_we;
    assign tcm_bus.dev_sel  = w_req && (w_region == soc_pkg::REGION_TCM);

    assign uart_bus.adr     = i_wb_adr;
    assign uart_bus.wdat    = i_wb_dat;
    assign uart_bus.sel     = i_wb_sel;
    assign uart_bus.we      = i_wb_we;
    assign uart_bus.dev_sel = w_req && (w_region == soc_pkg::REGION_UART);

    // free-running read-only cycle counter
    always_ff @(posedge w_clk)
    begin
        if (i_rst)
            r_cnt <= '0;
        else
            r_cnt <= r_cnt + 1'b1;
    end

    always_ff @(posedge w_clk)
    begin
        if (i_rst)
            r_ack <= 1'b0;
        else
            r_ack <= w_req & w_local & ~r_ack;   // one-cycle pulse
    end

    always_comb
    begin
        case (w_region)
            soc_pkg::REGION_TCM:
            begin
                o_wb_dat = tcm_bus.rdat;
                o_wb_ack = tcm_bus.ack;
            end
            soc_pkg::REGION_UART:
            begin
                o_wb_dat = uart_bus.rdat;
                o_wb_ack = uart_bus.ack;
            end
            soc_pkg::REGION_COUNTER:
            begin
                o_wb_dat = r_cnt;
                o_wb_ack = r_ack;
            end
            default:
            begin
                o_wb_dat = '0;              // unmapped reads as zero
                o_wb_ack = r_ack;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/tcm.sv
`timescale 1ns/1ns
`default_nettype none

module tcm
(
    input  logic           w_clk,
    wb_slave_if.peripheral bus
);

    localparam int LANES = $bits(soc_pkg::sel_t);

    soc_pkg::data_t    r_mem [0:soc_pkg::TCM_WORDS-1];
    soc_pkg::tcm_addr_t w_addr;
    logic              w_access;

    assign w_addr   = bus.adr[soc_pkg::TCM_ADDR_WIDTH+1:2];   // upper bits ignored so the address wraps
    assign w_access = bus.dev_sel & ~bus.ack;

    always_ff @(posedge w_clk)
    begin
        bus.ack <= w_access;
    end

    always_ff @(posedge w_clk)
    begin
        if (w_access)
            bus.rdat <= r_mem[w_addr];
    end

    always_ff @(posedge w_clk)
    begin
        if (w_access && bus.we)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (bus.sel[i])
                    r_mem[w_addr][8*i +: 8] <= bus.wdat[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/uart_wb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_wb
(
    input  logic           w_clk,
    input  logic           i_rst,
    wb_slave_if.peripheral bus,
    input  logic           i_rx,
    output logic           o_tx
);

    soc_pkg::baud_t          r_baud;
    logic [1:0]              w_reg;
    logic                    w_access;
    logic                    w_wr;
    logic                    w_rd_data;
    logic                    w_tx_start;
    logic                    w_tx_busy;

    soc_pkg::uart_tx_state_e r_tx_state;
    soc_pkg::baud_t          r_tx_clk_cnt;
    logic [2:0]              r_tx_bit_cnt;
    logic [7:0]              r_tx_shift;
    logic                    w_tx_bit_done;

    soc_pkg::uart_rx_state_e r_rx_state;
    logic [1:0]              r_rx_sync;
    logic                    w_rx_in;
    soc_pkg::baud_t          r_rx_clk_cnt;
    logic [2:0]              r_rx_bit_cnt;
    logic [7:0]              r_rx_shift;
    logic [7:0]              r_rx_data;
    logic                    r_rx_valid;
    logic                    w_rx_bit_done;
    logic                    w_rx_half;

    assign w_reg      = bus.adr[3:2];
    assign w_access   = bus.dev_sel & ~bus.ack;
    assign w_wr       = w_access & bus.we;
    assign w_rd_data  = w_access & ~bus.we & (w_reg == soc_pkg::UART_REG_DATA);
    assign w_tx_busy  = (r_tx_state != soc_pkg::TX_IDLE);
    assign w_tx_start = w_wr & (w_reg == soc_pkg::UART_REG_DATA) & ~w_tx_busy;   // dropped if busy

    always_ff @(posedge w_clk)
    begin
        if (i_rst)
        begin
            bus.ack <= 1'b0;
            r_baud  <= soc_pkg::UART_BAUD_RESET;
        end
        else
        begin
            bus.ack <= w_access;
            if (w_wr && w_reg == soc_pkg::UART_REG_BAUD)
                r_baud <= bus.wdat[15:0];
        end
    end

    always_ff @(posedge w_clk)
    begin
        if (w_access)
        begin
            case (w_reg)
                soc_pkg::UART_REG_DATA:   bus.rdat <= {24'd0, r_rx_data};
                soc_pkg::UART_REG_STATUS: bus.rdat <= {30'd0, r_rx_valid, w_tx_busy};
                soc_pkg::UART_REG_BAUD:   bus.rdat <= {16'd0, r_baud};
                default:                  bus.rdat <= '0;
            endcase
        end
    end

    // 8N1 transmitter sending lsb first
    assign w_tx_bit_done = (r_tx_clk_cnt == r_baud - 1'b1);

    always_ff @(posedge w_clk)
    begin
        if (i_rst)
        begin
            r_tx_state <= soc_pkg::TX_IDLE;
            o_tx       <= 1'b1;
        end
        else
        begin
            r_tx_clk_cnt <= w_tx_bit_done ? '0 : r_tx_clk_cnt + 1'b1;
            case (r_tx_state)
                soc_pkg::TX_IDLE:
                begin
                    if (w_tx_start)
                    begin
                        r_tx_state   <= soc_pkg::TX_START;
                        r_tx_shift   <= bus.wdat[7:0];
                        r_tx_clk_cnt <= '0;
                        o_tx         <= 1'b0;       // start bit
                    end
                end
                soc_pkg::TX_START:
                begin
                    if (w_tx_bit_done)
                    begin
                        r_tx_state   <= soc_pkg::TX_DATA;
                        r_tx_bit_cnt <= '0;
                        o_tx         <= r_tx_shift[0];
                        r_tx_shift   <= r_tx_shift >> 1;
                    end
                end
                soc_pkg::TX_DATA:
                begin
                    if (w_tx_bit_done)
                    begin
                        if (r_tx_bit_cnt == soc_pkg::UART_DATA_BITS - 1)
                        begin
                            r_tx_state <= soc_pkg::TX_STOP;
                            o_tx       <= 1'b1;
                        end
                        else
                        begin
                            r_tx_bit_cnt <= r_tx_bit_cnt + 1'b1;
                            o_tx         <= r_tx_shift[0];
                            r_tx_shift   <= r_tx_shift >> 1;
                        end
                    end
                end
                soc_pkg::TX_STOP:
                begin
                    if (w_tx_bit_done)
                        r_tx_state <= soc_pkg::TX_IDLE;
                end
                default: r_tx_state <= soc_pkg::TX_IDLE;
            endcase
        end
    end

    // receiver
    assign w_rx_in       = r_rx_sync[1];
    assign w_rx_bit_done = (r_rx_clk_cnt == r_baud - 1'b1);
    assign w_rx_half     = (r_rx_clk_cnt == (r_baud >> 1));

    always_ff @(posedge w_clk)
    begin
        if (i_rst)
        begin
            r_rx_sync  <= 2'b11;
            r_rx_state <= soc_pkg::RX_IDLE;
            r_rx_valid <= 1'b0;
        end
        else
        begin
            r_rx_sync    <= {r_rx_sync[0], i_rx};
            r_rx_clk_cnt <= w_rx_bit_done ? '0 : r_rx_clk_cnt + 1'b1;
            if (w_rd_data)
                r_rx_valid <= 1'b0;
            case (r_rx_state)
                soc_pkg::RX_IDLE:
                begin
                    r_rx_clk_cnt <= '0;
                    if (!w_rx_in)
                        r_rx_state <= soc_pkg::RX_START;
                end
                soc_pkg::RX_START:
                begin
                    if (w_rx_half)
                    begin
                        r_rx_clk_cnt <= '0;     // later samples land mid-bit
                        r_rx_bit_cnt <= '0;
                        r_rx_state   <= w_rx_in ? soc_pkg::RX_IDLE : soc_pkg::RX_DATA;
                    end
                end
                soc_pkg::RX_DATA:
                begin
                    if (w_rx_bit_done)
                    begin
                        r_rx_shift   <= {w_rx_in, r_rx_shift[7:1]};
                        r_rx_bit_cnt <= r_rx_bit_cnt + 1'b1;
                        if (r_rx_bit_cnt == soc_pkg::UART_DATA_BITS - 1)
                            r_rx_state <= soc_pkg::RX_STOP;
                    end
                end
                soc_pkg::RX_STOP:
                begin
                    if (w_rx_bit_done)
                    begin
                        r_rx_state <= soc_pkg::RX_IDLE;
                        if (w_rx_in)            // framing error drops the byte
                        begin
                            r_rx_data  <= r_rx_shift;
                            r_rx_valid <= 1'b1;
                        end
                    end
                end
                default: r_rx_state <= soc_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/soc_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_top
(
    input  logic           w_clk,
    input  logic           i_rst,
    input  logic           i_wb_cyc,
    input  logic           i_wb_stb,
    input  logic           i_wb_we,
    input  soc_pkg::addr_t i_wb_adr,
    input  soc_pkg::sel_t  i_wb_sel,
    input  soc_pkg::data_t i_wb_dat,
    output soc_pkg::data_t o_wb_dat,
    output logic           o_wb_ack,
    input  logic           i_rx,
    output logic           o_tx
);

    logic w_rst;

    wb_slave_if tcm_bus();
    wb_slave_if uart_bus();

    reset_filter u_reset_filter
    (
        .w_clk      (w_clk),
        .i_rst      (i_rst),
        .o_rst      (w_rst)
    );

    bus_fabric u_bus_fabric
    (
        .w_clk      (w_clk),
        .i_rst      (w_rst),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_sel   (i_wb_sel),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .tcm_bus    (tcm_bus.fabric),
        .uart_bus   (uart_bus.fabric)
    );

    tcm u_tcm
    (
        .w_clk      (w_clk),
        .bus        (tcm_bus.peripheral)
    );

    uart_wb u_uart
    (
        .w_clk      (w_clk),
        .i_rst      (w_rst),
        .bus        (uart_bus.peripheral),
        .i_rx       (i_rx),
        .o_tx       (o_tx)
    );

endmodule

`default_nettype wire

//--- tests/tb_soc_tasks.svh
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

// one classic bus cycle entered and left 1 ns after a rising edge
task automatic wb_cycle
(
    input  logic           we,
    input  soc_pkg::addr_t adr,
    input  soc_pkg::data_t wdat,
    input  soc_pkg::sel_t  sel,
    output soc_pkg::data_t rdat
);
    int waited;
    waited   = 0;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_sel = sel;
    i_wb_dat = wdat;
    do
    begin
        @(posedge w_clk);
        #1;
        waited++;
        if (waited > ACK_TIMEOUT)
            stop_run($sformatf("no ack from address %08h in test %s", adr, test_name));
    end
    while (o_wb_ack !== 1'b1);
    rdat           = o_wb_dat;          // valid in the ack cycle only
    last_ack_cycle = cycle_count;
    @(posedge w_clk);
    #1;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    @(posedge w_clk);                   // one idle cycle before the next request
    #1;
endtask

task automatic wb_write
(
    input soc_pkg::addr_t adr,
    input soc_pkg::data_t dat,
    input soc_pkg::sel_t  sel
);
    soc_pkg::data_t unused;
    wb_cycle(1'b1, adr, dat, sel, unused);
endtask

task automatic wb_read
(
    input  soc_pkg::addr_t adr,
    output soc_pkg::data_t dat
);
    wb_cycle(1'b0, adr, '0, 4'hf, dat);
endtask

// 8N1 frame sent lsb first
task automatic uart_send_byte
(
    input soc_pkg::baud_t period,
    input logic [7:0]     value
);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
        i_rx = frame[i];
        repeat (period) @(posedge w_clk);
        #1;
    end
endtask

task automatic uart_capture_byte
(
    input  soc_pkg::baud_t period,
    output logic [7:0]     value
);
    int         waited;
    logic [7:0] bits;
    waited = 0;
    while (o_tx !== 1'b0)
    begin
        @(posedge w_clk);
        #1;
        waited++;
        if (waited > CAPTURE_TIMEOUT)
            stop_run($sformatf("no start bit on o_tx in test %s", test_name));
    end
    repeat (period / 2) @(posedge w_clk);   // move to mid-bit
    #1;
    check_equal($sformatf("%s start bit", test_name), 32'd0, {31'd0, o_tx});
    for (int i = 0; i < 8; i++)
    begin
        repeat (period) @(posedge w_clk);
        #1;
        bits[i] = o_tx;
    end
    repeat (period) @(posedge w_clk);
    #1;
    check_equal($sformatf("%s stop bit", test_name), 32'd1, {31'd0, o_tx});
    value = bits;
endtask

`endif

//--- tests/tb_soc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc;

    localparam int             ACK_TIMEOUT     = 16;
    localparam int             CAPTURE_TIMEOUT = 64;
    localparam int             POLL_LIMIT      = 20;
    localparam soc_pkg::baud_t BIT_PERIOD      = 16'd8;
    localparam soc_pkg::addr_t UART_DATA_ADR   = 32'h1000_0000;
    localparam soc_pkg::addr_t UART_STATUS_ADR = 32'h1000_0004;
    localparam soc_pkg::addr_t UART_BAUD_ADR   = 32'h1000_0008;
    localparam soc_pkg::addr_t COUNTER_ADR     = 32'h2000_0000;

    logic           w_clk;
    logic           i_rst;
    logic           i_wb_cyc;
    logic           i_wb_stb;
    logic           i_wb_we;
    soc_pkg::addr_t i_wb_adr;
    soc_pkg::sel_t  i_wb_sel;
    soc_pkg::data_t i_wb_dat;
    soc_pkg::data_t o_wb_dat;
    logic           o_wb_ack;
    logic           i_rx;
    logic           o_tx;

    string          test_name = "reset";
    int unsigned    cycle_count = 0;
    int unsigned    last_ack_cycle;
    soc_pkg::data_t tcm_model [0:1023];         // indexed by address bits 11:2

    soc_top u_soc_top
    (
        .w_clk    (w_clk),
        .i_rst    (i_rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_sel (i_wb_sel),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .i_rx     (i_rx),
        .o_tx     (o_tx)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
            stop_run($sformatf("ERROR %s expected %08h actual %08h", what, exp, act));
    endtask

    function automatic soc_pkg::data_t merge_lanes(soc_pkg::data_t old_word,
                                                   soc_pkg::data_t new_word,
                                                   soc_pkg::sel_t sel);
        soc_pkg::data_t res;
        for (int i = 0; i < 4; i++)
            res[8*i +: 8] = sel[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
        return res;
    endfunction

    `include "tb_soc_tasks.svh"

    initial
    begin
        w_clk = 1'b0;
        forever #50 w_clk = ~w_clk;
    end

    always @(posedge w_clk)
        cycle_count <= cycle_count + 1;

    ack_after_request: assert property (@(posedge w_clk) disable iff (i_rst)
        $rose(i_wb_cyc && i_wb_stb) |-> !o_wb_ack ##1 o_wb_ack)
    else
        stop_run($sformatf("ack did not follow the request by one cycle in test %s", test_name));

    ack_needs_cyc: assert property (@(posedge w_clk) disable iff (i_rst)
        o_wb_ack |-> i_wb_cyc)
    else
        stop_run($sformatf("ack was high without cyc in test %s", test_name));

    initial
    begin
        soc_pkg::addr_t adr_list [0:31];
        soc_pkg::addr_t adr;
        soc_pkg::data_t rdata;
        soc_pkg::data_t wdata;
        soc_pkg::data_t first_cnt;
        soc_pkg::sel_t  sel;
        int unsigned    first_ack;
        logic [7:0]     tx_byte;
        logic [7:0]     got_byte;
        int             polls;

        void'($urandom(32'hb09f_1cff));
        i_rst    = 1'b1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_sel = '0;
        i_wb_dat = '0;
        i_rx     = 1'b1;            // idle line
        repeat (10) @(posedge w_clk);
        #1;
        i_rst = 1'b0;
        repeat (soc_pkg::RST_HOLD_CYCLES + 4) @(posedge w_clk);   // internal reset release
        #1;
        check_equal("reset o_tx", 32'd1, {31'd0, o_tx});
        check_equal("reset o_wb_ack", 32'd0, {31'd0, o_wb_ack});

        test_name = "tcm_rw";
        for (int n = 0; n < 32; n++)
        begin
            wdata       = $urandom();
            adr         = $urandom();
            adr_list[n] = {4'h0, adr[27:2], 2'b00};   // upper bits exercise the wrap
            wb_write(adr_list[n], wdata, 4'hf);
            tcm_model[adr_list[n][11:2]] = wdata;
        end
        for (int n = 0; n < 32; n++)
        begin
            wb_read(adr_list[n], rdata);
            check_equal(test_name, tcm_model[adr_list[n][11:2]], rdata);
        end

        test_name = "tcm_lanes";
        for (int n = 0; n < 8; n++)
        begin
            adr = {20'h0_0000, 10'($urandom()), 2'b00};
            wb_write(adr, 32'h5aa5_c33c, 4'hf);
            wdata = $urandom();
            sel   = 4'($urandom());
            wb_write(adr, wdata, sel);
            tcm_model[adr[11:2]] = merge_lanes(32'h5aa5_c33c, wdata, sel);
            wb_read(adr, rdata);
            check_equal(test_name, tcm_model[adr[11:2]], rdata);
        end

        test_name = "counter_region";
        wb_read(COUNTER_ADR, first_cnt);
        first_ack = last_ack_cycle;
        for (int n = 0; n < 3; n++)
            wb_read(adr_list[n], rdata);
        wb_read(COUNTER_ADR, rdata);
        check_equal(test_name, 32'(last_ack_cycle - first_ack), rdata - first_cnt);

        test_name = "unmapped_region";
        wb_write(32'h0000_0100, 32'hdead_0100, 4'hf);
        tcm_model[10'h040] = 32'hdead_0100;
        for (int r = 3; r < 16; r++)
        begin
            wb_read({4'(r), 28'h000_0100}, rdata);
            check_equal(test_name, 32'd0, rdata);
            wb_write({4'(r), 28'h000_0100}, $urandom(), 4'hf);
        end
        wb_read(32'h0000_0100, rdata);
        check_equal(test_name, tcm_model[10'h040], rdata);

        test_name = "uart_tx";
        wb_read(UART_BAUD_ADR, rdata);
        check_equal(test_name, 32'd16, rdata);
        wb_read(UART_STATUS_ADR, rdata);
        check_equal(test_name, 32'd0, rdata);
        wb_write(UART_BAUD_ADR, {16'd0, BIT_PERIOD}, 4'hf);
        tx_byte = 8'($urandom());
        fork
            uart_capture_byte(BIT_PERIOD, got_byte);
            begin
                wb_write(UART_DATA_ADR, {24'd0, tx_byte}, 4'hf);
                wb_read(UART_STATUS_ADR, wdata);
                check_equal(test_name, 32'h1, wdata);   // busy
            end
        join
        check_equal(test_name, {24'd0, tx_byte}, {24'd0, got_byte});
        repeat (2 * BIT_PERIOD) @(posedge w_clk);    // rest of the stop bit
        #1;
        wb_read(UART_STATUS_ADR, rdata);
        check_equal(test_name, 32'd0, rdata);

        test_name = "uart_rx";
        tx_byte = 8'($urandom());
        uart_send_byte(BIT_PERIOD, tx_byte);
        polls = 0;
        rdata = '0;
        while (rdata[1] !== 1'b1)
        begin
            wb_read(UART_STATUS_ADR, rdata);
            polls++;
            if (polls > POLL_LIMIT)
                stop_run("receive valid bit never set after the frame in test uart_rx");
        end
        wb_read(UART_DATA_ADR, rdata);
        check_equal(test_name, {24'd0, tx_byte}, rdata);
        wb_read(UART_STATUS_ADR, rdata);
        check_equal(test_name, 32'd0, rdata);        // valid cleared by the read

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+tests
source/soc_pkg.sv
source/wb_slave_if.sv
source/reset_filter.sv
source/bus_fabric.sv
source/tcm.sv
source/uart_wb.sv
source/soc_top.sv
tests/tb_soc.sv
